//--- files.f
+incdir+design
design/alu_pkg.sv
design/div_if.sv
design/ks_adder.sv
design/mul_unit.sv
design/div_unit.sv
design/alu_top.sv
sim/alu_asserts.sv
sim/alu_tb.sv

//--- Bender.yml
package:
  name: alu

sources:
  - include_dirs:
      - design
    files:
      - design/alu_pkg.sv
      - design/div_if.sv
      - design/ks_adder.sv
      - design/mul_unit.sv
      - design/div_unit.sv
      - design/alu_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/alu_asserts.sv
      - sim/alu_tb.sv

//--- sim/alu_tb.sv
`include "alu_consts.svh"

module alu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import alu_pkg::*;

    localparam int READY_TIMEOUT = 40;

    logic    clk;
    logic    rst_n;
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   result;
    logic    flag_n;
    logic    flag_z;
    logic    flag_c;
    logic    flag_v;
    logic    ready;

    alu_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_i     (op),
        .a_i      (a),
        .b_i      (b),
        .result_o (result),
        .flag_n_o (flag_n),
        .flag_z_o (flag_z),
        .flag_c_o (flag_c),
        .flag_v_o (flag_v),
        .ready_o  (ready)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic word_t expected_div(alu_op_e op_in, word_t a_in, word_t b_in);
        logic  is_signed;
        logic  want_rem;
        word_t int_min;
        is_signed = op_in inside {DIV, REM};
        want_rem  = op_in inside {REM, REMU};
        int_min   = {1'b1, {(`ALU_XLEN-1){1'b0}}};
        // divide by zero keeps the dividend as remainder
        if (b_in == '0) begin
            return want_rem ? a_in : '1;
        end
        if (is_signed && a_in == int_min && b_in == '1) begin
            return want_rem ? '0 : a_in;
        end
        if (is_signed) begin
            return want_rem ? word_t'($signed(a_in) % $signed(b_in))
                            : word_t'($signed(a_in) / $signed(b_in));
        end
        return want_rem ? a_in % b_in : a_in / b_in;
    endfunction

    function automatic word_t expected_result(alu_op_e op_in, word_t a_in, word_t b_in);
        logic [`ALU_SHAMT_W-1:0] sh;
        logic [2*`ALU_XLEN-1:0]  a_sx;
        logic [2*`ALU_XLEN-1:0]  b_sx;
        logic [2*`ALU_XLEN-1:0]  a_zx;
        logic [2*`ALU_XLEN-1:0]  b_zx;
        logic [2*`ALU_XLEN-1:0]  prod;
        word_t                   fill;
        sh   = b_in[`ALU_SHAMT_W-1:0];
        a_sx = {{`ALU_XLEN{a_in[`ALU_XLEN-1]}}, a_in};
        b_sx = {{`ALU_XLEN{b_in[`ALU_XLEN-1]}}, b_in};
        a_zx = {{`ALU_XLEN{1'b0}}, a_in};
        b_zx = {{`ALU_XLEN{1'b0}}, b_in};
        // vacated upper bits for an arithmetic shift
        fill = a_in[`ALU_XLEN-1] ? ~({`ALU_XLEN{1'b1}} >> sh) : '0;
        case (op_in)
            ADD:    return a_in + b_in;
            SUB:    return a_in - b_in;
            AND:    return a_in & b_in;
            OR:     return a_in | b_in;
            XOR:    return a_in ^ b_in;
            SLL:    return a_in << sh;
            SRL:    return a_in >> sh;
            SRA:    return (a_in >> sh) | fill;
            SLT:    return word_t'($signed(a_in) < $signed(b_in));
            SLTU:   return word_t'(a_in < b_in);
            MUL:    return a_in * b_in;
            MULH: begin
                prod = a_sx * b_sx;
                return prod[2*`ALU_XLEN-1:`ALU_XLEN];
            end
            MULHSU: begin
                prod = a_sx * b_zx;
                return prod[2*`ALU_XLEN-1:`ALU_XLEN];
            end
            MULHU: begin
                prod = a_zx * b_zx;
                return prod[2*`ALU_XLEN-1:`ALU_XLEN];
            end
            default: return expected_div(op_in, a_in, b_in);
        endcase
    endfunction

    // n, z, c, v packed msb first
    function automatic logic [3:0] expected_flags(alu_op_e op_in, word_t a_in, word_t b_in);
        logic [`ALU_XLEN:0] wide;
        longint             s_sum;
        word_t              sum;
        if (op_in inside {SUB, SLT, SLTU}) begin
            wide  = {1'b0, a_in} + {1'b0, ~b_in} + 1;
            s_sum = longint'($signed(a_in)) - longint'($signed(b_in));
        end else begin
            wide  = {1'b0, a_in} + {1'b0, b_in};
            s_sum = longint'($signed(a_in)) + longint'($signed(b_in));
        end
        sum = wide[`ALU_XLEN-1:0];
        return {sum[`ALU_XLEN-1], sum == '0, wide[`ALU_XLEN], s_sum != longint'($signed(sum))};
    endfunction

    ////////////////////////////////////////////////////////////
    // compare and drive
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_flags(input logic exp_n, input logic exp_z,
                               input logic exp_c, input logic exp_v);
        check_bit("flag_n_o", flag_n, exp_n);
        check_bit("flag_z_o", flag_z, exp_z);
        check_bit("flag_c_o", flag_c, exp_c);
        check_bit("flag_v_o", flag_v, exp_v);
    endtask

    task automatic drive_op(input alu_op_e op_in, input word_t a_in, input word_t b_in);
        @(posedge clk);
        #1;
        op = op_in;
        a  = a_in;
        b  = b_in;
    endtask

    // single-cycle op, sampled at the falling edge
    task automatic check_comb(input alu_op_e op_in, input word_t a_in, input word_t b_in);
        logic [3:0] exp_f;
        exp_f = expected_flags(op_in, a_in, b_in);
        drive_op(op_in, a_in, b_in);
        @(negedge clk);
        check_bit("ready_o", ready, 1'b1);
        check_word($sformatf("result_o (%s)", op_in.name()), result,
                   expected_result(op_in, a_in, b_in));
        check_flags(exp_f[3], exp_f[2], exp_f[1], exp_f[0]);
    endtask

    task automatic check_divide(input alu_op_e op_in, input word_t a_in, input word_t b_in);
        int waited;
        drive_op(op_in, a_in, b_in);
        waited = 0;
        @(negedge clk);
        while (ready !== 1'b1) begin
            waited++;
            if (waited > READY_TIMEOUT) begin
                abort_run("timeout: ready_o did not rise within 40 cycles of a divide");
            end
            @(negedge clk);
        end
        if (waited == 0) begin
            abort_run("ready_o was high in the first cycle of a divide");
        end
        check_word($sformatf("result_o (%s)", op_in.name()), result,
                   expected_div(op_in, a_in, b_in));
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_ready();
        @(negedge clk);
        check_bit("ready_o", ready, 1'b1);
    endtask

    task automatic add_sub_corners();
        check_comb(ADD, 32'h0000_0001, 32'h0000_0002);
        check_comb(ADD, 32'h7fff_ffff, 32'h0000_0001);
        check_comb(ADD, 32'hffff_ffff, 32'h0000_0001);
        check_comb(ADD, 32'h8000_0000, 32'h8000_0000);
        check_comb(SUB, 32'h0000_0005, 32'h0000_0005);
        check_comb(SUB, 32'h0000_0000, 32'h0000_0001);
        check_comb(SUB, 32'h8000_0000, 32'h0000_0001);
        check_comb(SUB, 32'h7fff_ffff, 32'hffff_ffff);
    endtask

    task automatic logic_shift_compare();
        alu_op_e ops[10] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU};
        word_t   ra;
        word_t   rb;
        check_comb(AND,  32'hf0f0_1234, 32'h0ff0_ffff);
        check_comb(OR,   32'h8000_0000, 32'h0000_0001);
        check_comb(XOR,  32'hffff_ffff, 32'h1234_5678);
        check_comb(SLL,  32'h8000_0001, 32'h0000_0000);
        check_comb(SLL,  32'h0000_0003, 32'h0000_001f);
        check_comb(SRL,  32'h8000_0000, 32'h0000_001f);
        check_comb(SRA,  32'h8000_0000, 32'h0000_001f);
        check_comb(SRA,  32'hf000_0000, 32'hffff_ffe4);
        check_comb(SLT,  32'hffff_fffe, 32'h0000_0001);
        check_comb(SLT,  32'h8000_0000, 32'h7fff_ffff);
        check_comb(SLTU, 32'hffff_fffe, 32'h0000_0001);
        check_comb(SLTU, 32'h0000_0003, 32'h0000_0003);
        for (int i = 0; i < 20; i++) begin
            ra = $urandom;
            rb = $urandom;
            foreach (ops[k]) begin
                check_comb(ops[k], ra, rb);
            end
        end
    endtask

    task automatic multiply_variants();
        alu_op_e mops[4] = '{MUL, MULH, MULHSU, MULHU};
        word_t   vals[6] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
                             32'hffff_8000};
        foreach (mops[k]) begin
            foreach (vals[i]) begin
                foreach (vals[j]) begin
                    check_comb(mops[k], vals[i], vals[j]);
                end
            end
            for (int r = 0; r < 10; r++) begin
                check_comb(mops[k], $urandom, $urandom);
            end
        end
    endtask

    task automatic random_divides();
        alu_op_e dops[4] = '{DIV, DIVU, REM, REMU};
        word_t   ra;
        word_t   rb;
        for (int i = 0; i < 6; i++) begin
            ra = $urandom;
            // vary the divisor magnitude
            rb = $urandom >> $urandom_range(0, `ALU_XLEN-1);
            foreach (dops[k]) begin
                check_divide(dops[k], ra, rb);
            end
        end
    endtask

    task automatic divide_corner_cases();
        check_divide(DIV,  32'h1234_5678, 32'h0);
        check_divide(DIVU, 32'h8765_4321, 32'h0);
        check_divide(REM,  32'hffff_fff9, 32'h0);
        check_divide(REMU, 32'h1234_5678, 32'h0);
        check_divide(DIV,  32'h8000_0000, 32'hffff_ffff);
        check_divide(REM,  32'h8000_0000, 32'hffff_ffff);
        check_divide(DIVU, 32'h8000_0000, 32'hffff_ffff);
        check_divide(DIV,  32'hffff_fff9, 32'h0000_0002);
        check_divide(REM,  32'hffff_fff9, 32'h0000_0002);
    endtask

    // one add cycle between divides
    task automatic back_to_back_divides();
        check_divide(DIV,  32'h0001_e240, 32'hffff_fc18);
        check_comb(ADD,    32'h0000_1000, 32'h0000_0234);
        check_divide(REM,  32'hfffe_1dc0, 32'h0000_0007);
        check_comb(ADD,    32'hffff_ffff, 32'hffff_ffff);
        check_divide(DIVU, 32'hdead_beef, 32'h0000_1234);
        check_comb(ADD,    32'h7fff_0000, 32'h0000_ffff);
        check_divide(REMU, 32'hdead_beef, 32'h0000_1234);
        check_comb(ADD,    32'h0, 32'h0);
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        op    = ADD;
        a     = '0;
        b     = '0;
        void'($urandom(38));
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_ready();
        add_sub_corners();
        logic_shift_compare();
        multiply_variants();
        random_divides();
        divide_corner_cases();
        back_to_back_divides();
        if (dut_i.u_asserts.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("%0d assertion failures", dut_i.u_asserts.fail_count);
            $display("tests failed");
            $fatal(1);
        end
    end

endmodule

//--- sim/alu_asserts.sv
`include "alu_consts.svh"

module alu_asserts (
    input logic                clk,
    input logic                rst_n,
    input alu_pkg::alu_op_e    op_i,
    input alu_pkg::word_t      result_o,
    input logic                ready_o,
    input alu_pkg::div_state_e div_state_i
);
    timeunit 1ns;
    timeprecision 1ps;

    import alu_pkg::*;

    int unsigned fail_count = 0;

    logic is_div;

    assign is_div = op_i inside {DIV, DIVU, REM, REMU};

    // everything but a divide completes in the same cycle
    comb_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !is_div |-> ready_o)
    else begin
        fail_count++;
        $error("ready_o low for a single-cycle operation");
    end

    // divider leaves idle on a held divide and must report back
    div_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (is_div && div_state_i == DIV_IDLE) |-> ##[1:`ALU_DIV_STEPS+2] ready_o)
    else begin
        fail_count++;
        $error("divide did not raise ready_o in time");
    end

    result_known: assert property (@(posedge clk) disable iff (!rst_n)
        ready_o |-> !$isunknown(result_o))
    else begin
        fail_count++;
        $error("result_o has unknown bits while ready_o is high");
    end

endmodule

bind alu_top alu_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .op_i        (op_i),
    .result_o    (result_o),
    .ready_o     (ready_o),
    .div_state_i (u_div.state_q)
);

//--- design/alu_top.sv
`include "alu_consts.svh"

module alu_top (
    input  logic             clk,
    input  logic             rst_n,
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::word_t   a_i,
    input  alu_pkg::word_t   b_i,
    output alu_pkg::word_t   result_o,
    output logic             flag_n_o,
    output logic             flag_z_o,
    output logic             flag_c_o,
    output logic             flag_v_o,
    output logic             ready_o
);
    import alu_pkg::*;

    logic                    sub_sel;
    logic                    div_req;
    word_t                   add_b;
    word_t                   sum;
    word_t                   prod;
    logic [`ALU_SHAMT_W-1:0] shamt;
    logic                    slt;
    logic                    sltu;

    div_if div_bus ();

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    // compares run through the adder as a subtract
    assign sub_sel = op_i inside {SUB, SLT, SLTU};
    assign div_req = op_i inside {DIV, DIVU, REM, REMU};

    assign add_b = sub_sel ? ~b_i : b_i;

    ks_adder u_adder (
        .a_i   (a_i),
        .b_i   (add_b),
        .cin_i (sub_sel),
        .sum_o (sum),
        .n_o   (flag_n_o),
        .z_o   (flag_z_o),
        .c_o   (flag_c_o),
        .v_o   (flag_v_o)
    );

    mul_unit u_mul (
        .a_i    (a_i),
        .b_i    (b_i),
        .op_i   (op_i),
        .prod_o (prod)
    );

    // divide request stays up as long as the operation is held
    assign div_bus.start     = div_req;
    assign div_bus.dividend  = a_i;
    assign div_bus.divisor   = b_i;
    assign div_bus.is_signed = op_i inside {DIV, REM};
    assign div_bus.want_rem  = op_i inside {REM, REMU};

    div_unit u_div (
        .clk   (clk),
        .rst_n (rst_n),
        .div   (div_bus.divider)
    );

    ////////////////////////////////////////////////////////////
    // shift, compare and result select
    ////////////////////////////////////////////////////////////

    assign shamt = b_i[`ALU_SHAMT_W-1:0];

    // signed less-than from n and v, unsigned from borrow
    assign slt  = flag_n_o ^ flag_v_o;
    assign sltu = ~flag_c_o;

    always_comb begin
        case (op_i)
            ADD, SUB:                 result_o = sum;
            AND:                      result_o = a_i & b_i;
            OR:                       result_o = a_i | b_i;
            XOR:                      result_o = a_i ^ b_i;
            SLL:                      result_o = a_i << shamt;
            SRL:                      result_o = a_i >> shamt;
            SRA:                      result_o = word_t'($signed(a_i) >>> shamt);
            SLT:                      result_o = {{(`ALU_XLEN-1){1'b0}}, slt};
            SLTU:                     result_o = {{(`ALU_XLEN-1){1'b0}}, sltu};
            MUL, MULH, MULHSU, MULHU: result_o = prod;
            DIV, DIVU, REM, REMU:     result_o = div_bus.result;
            default:                  result_o = '0;
        endcase
    end

    // only divides take more than one cycle
    assign ready_o = div_req ? div_bus.done : 1'b1;

endmodule

//--- design/div_unit.sv
`include "alu_consts.svh"

module div_unit (
    input  logic   clk,
    input  logic   rst_n,
    div_if.divider div
);
    import alu_pkg::*;

    div_state_e state_q;
    div_state_e state_d;

    // one-hot pointer to the quotient bit being resolved
    logic [`ALU_DIV_STEPS-1:0] mask_q;

    word_t rem_q;
    word_t quot_q;
    word_t dvd_q;
    word_t divisor_q;
    logic  neg_quot_q;
    logic  neg_rem_q;
    logic  want_rem_q;

    word_t              dividend_abs;
    word_t              divisor_abs;
    logic               neg_quot;
    logic               neg_rem;
    logic [`ALU_XLEN:0] trial;
    logic               fits;
    word_t              rem_step;
    word_t              quot_fix;
    word_t              rem_fix;

    ////////////////////////////////////////////////////////////
    // operand preparation
    ////////////////////////////////////////////////////////////

    // magnitudes for signed divides, -2^31 maps to 2^31 unsigned
    assign dividend_abs = (div.is_signed && div.dividend[`ALU_XLEN-1]) ?
                          -div.dividend : div.dividend;
    assign divisor_abs  = (div.is_signed && div.divisor[`ALU_XLEN-1]) ?
                          -div.divisor : div.divisor;

    // quotient keeps all ones on divide by zero
    assign neg_quot = div.is_signed & (|div.divisor) &
                      (div.dividend[`ALU_XLEN-1] ^ div.divisor[`ALU_XLEN-1]);

    // remainder takes the sign of the dividend
    assign neg_rem  = div.is_signed & div.dividend[`ALU_XLEN-1];

    ////////////////////////////////////////////////////////////
    // restoring step
    ////////////////////////////////////////////////////////////

    // partial remainder with the next dividend bit shifted in
    assign trial = {rem_q, dvd_q[`ALU_XLEN-1]};
    assign fits  = trial >= {1'b0, divisor_q};

    // result of a fitting subtract is below the divisor, so 32 bits suffice
    assign rem_step = fits ? (trial[`ALU_XLEN-1:0] - divisor_q) : trial[`ALU_XLEN-1:0];

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            DIV_IDLE: begin
                if (div.start) begin
                    state_d = DIV_RUN;
                end
            end
            DIV_RUN: begin
                // last quotient bit resolved this cycle
                if (mask_q[0]) begin
                    state_d = DIV_DONE;
                end
            end
            DIV_DONE: begin
                state_d = DIV_IDLE;
            end
            default: begin
                state_d = DIV_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= DIV_IDLE;
            mask_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == DIV_IDLE) begin
                mask_q <= {1'b1, {(`ALU_DIV_STEPS-1){1'b0}}};
            end else if (state_q == DIV_RUN) begin
                mask_q <= mask_q >> 1;
            end
        end
    end

    // datapath, loaded while idle and stepped while running
    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE) begin
            rem_q      <= '0;
            quot_q     <= '0;
            dvd_q      <= dividend_abs;
            divisor_q  <= divisor_abs;
            neg_quot_q <= neg_quot;
            neg_rem_q  <= neg_rem;
            want_rem_q <= div.want_rem;
        end else if (state_q == DIV_RUN) begin
            rem_q <= rem_step;
            dvd_q <= dvd_q << 1;
            if (fits) begin
                quot_q <= quot_q | mask_q;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // sign correction and response
    ////////////////////////////////////////////////////////////

    assign quot_fix = neg_quot_q ? -quot_q : quot_q;
    assign rem_fix  = neg_rem_q ? -rem_q : rem_q;

    assign div.result = want_rem_q ? rem_fix : quot_fix;
    assign div.done   = (state_q == DIV_DONE);

endmodule

//--- design/mul_unit.sv
`include "alu_consts.svh"

module mul_unit (
    input  alu_pkg::word_t   a_i,
    input  alu_pkg::word_t   b_i,
    input  alu_pkg::alu_op_e op_i,
    output alu_pkg::word_t   prod_o
);
    import alu_pkg::*;

    logic                          a_sign;
    logic                          b_sign;
    logic signed [`ALU_XLEN:0]     a_ext;
    logic signed [`ALU_XLEN:0]     b_ext;
    logic signed [2*`ALU_XLEN+1:0] prod_full;

    // a is unsigned only for mulhu, b for mulhsu and mulhu
    assign a_sign = (op_i != MULHU) & a_i[`ALU_XLEN-1];
    assign b_sign = (op_i inside {MUL, MULH}) & b_i[`ALU_XLEN-1];

    assign a_ext = {a_sign, a_i};
    assign b_ext = {b_sign, b_i};

    // 33x33 signed, both extensions covered by one multiplier
    assign prod_full = a_ext * b_ext;

    always_comb begin
        case (op_i)
            MUL:                 prod_o = prod_full[`ALU_XLEN-1:0];
            MULH, MULHSU, MULHU: prod_o = prod_full[2*`ALU_XLEN-1:`ALU_XLEN];
            default:             prod_o = '0;
        endcase
    end

endmodule

//--- design/ks_adder.sv
`include "alu_consts.svh"

module ks_adder (
    input  alu_pkg::word_t a_i,
    input  alu_pkg::word_t b_i,
    input  logic           cin_i,
    output alu_pkg::word_t sum_o,
    output logic           n_o,
    output logic           z_o,
    output logic           c_o,
    output logic           v_o
);
    import alu_pkg::*;

    word_t p_bit;
    word_t carry_in;

    // group generate and propagate, one entry per prefix stage
    word_t gen  [0:$clog2(`ALU_XLEN)];
    word_t prop [0:$clog2(`ALU_XLEN)-1];

    assign p_bit = a_i ^ b_i;

    // carry-in folded into the bit 0 generate
    assign gen[0]  = (a_i & b_i) | {{(`ALU_XLEN-1){1'b0}}, p_bit[0] & cin_i};
    assign prop[0] = p_bit;

    ////////////////////////////////////////////////////////////
    // prefix tree, spans 1, 2, 4, 8, 16
    ////////////////////////////////////////////////////////////

    for (genvar s = 0; s < $clog2(`ALU_XLEN); s++) begin : g_stage
        for (genvar i = 0; i < `ALU_XLEN; i++) begin : g_bit
            if (i >= (1 << s)) begin : g_cell
                // combine with the group one span below
                assign gen[s+1][i] = gen[s][i] | (prop[s][i] & gen[s][i-(1<<s)]);
                if (s < $clog2(`ALU_XLEN) - 1) begin : g_prop
                    assign prop[s+1][i] = prop[s][i] & prop[s][i-(1<<s)];
                end
            end else begin : g_pass
                // group already reaches bit 0
                assign gen[s+1][i] = gen[s][i];
                if (s < $clog2(`ALU_XLEN) - 1) begin : g_prop
                    assign prop[s+1][i] = prop[s][i];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // sum and flags
    ////////////////////////////////////////////////////////////

    // carry into bit i is the group generate of bits i-1 down to 0
    assign carry_in = {gen[$clog2(`ALU_XLEN)][`ALU_XLEN-2:0], cin_i};
    assign sum_o    = p_bit ^ carry_in;

    assign n_o = sum_o[`ALU_XLEN-1];
    assign z_o = (sum_o == '0);
    assign c_o = gen[$clog2(`ALU_XLEN)][`ALU_XLEN-1];

    // carry out of the msb differs from carry into it
    assign v_o = gen[$clog2(`ALU_XLEN)][`ALU_XLEN-1] ^ carry_in[`ALU_XLEN-1];

endmodule

//--- design/div_if.sv
interface div_if;
    import alu_pkg::*;

    // request, held by the requester until done
    logic  start;
    word_t dividend;
    word_t divisor;
    logic  is_signed;
    logic  want_rem;

    // response, result only meaningful while done is high
    word_t result;
    logic  done;

    modport requester (
        output start, dividend, divisor, is_signed, want_rem,
        input  result, done
    );

    modport divider (
        input  start, dividend, divisor, is_signed, want_rem,
        output result, done
    );

endinterface

//--- design/alu_pkg.sv
`include "alu_consts.svh"

package alu_pkg;

    typedef logic [`ALU_XLEN-1:0] word_t;

    // bit 4 marks the M extension, bit 3 the divide group within it
    typedef enum logic [4:0] {
        ADD    = 5'h00,
        SUB    = 5'h01,
        AND    = 5'h02,
        OR     = 5'h03,
        XOR    = 5'h04,
        SLL    = 5'h05,
        SRL    = 5'h06,
        SRA    = 5'h07,
        SLT    = 5'h08,
        SLTU   = 5'h09,
        // multiplies
        MUL    = 5'h10,
        MULH   = 5'h11,
        MULHSU = 5'h12,
        MULHU  = 5'h13,
        // divides and remainders
        DIV    = 5'h18,
        DIVU   = 5'h19,
        REM    = 5'h1a,
        REMU   = 5'h1b
    } alu_op_e;

    // divider sequencing
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

endpackage

//--- design/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// data word width, fixed by the RV32 ISA
`define ALU_XLEN 32

// shift amount taken from the low bits of operand b
`define ALU_SHAMT_W 5

// one quotient bit per divider step
`define ALU_DIV_STEPS `ALU_XLEN

`endif
